//--- hw/gb_video_pkg.sv
//####################
// video widths shared by the object layer
// coordinates are 8-bit LCD counters, tile area is 4 KiB per bank
//####################
`default_nettype none

package gb_video_pkg;

	// line or pixel counter, also a sprite x or y position
	typedef logic [7:0] coord_t;

	// one byte of video memory
	typedef logic [7:0] vram_byte_t;

	// tile number and row inside the tile, as produced by a slot
	typedef logic [10:0] tile_row_t;

	// tile-row index followed by the plane bit
	typedef logic [11:0] vram_addr_t;

	// sprite y is stored with 16 added, so y=0 is fully above the screen
	localparam int OBJ_Y_OFS = 16;

	// sprite x is stored with 8 added, so x=0 is fully left of the screen
	localparam int OBJ_X_OFS = 8;

endpackage

`default_nettype wire

//--- hw/sprite_pkg.sv
//####################
// object attribute and sprite pixel layout
// at most 16 slots, the slot index is 4 bits wide
//####################
`default_nettype none

package sprite_pkg;

	// largest slot count the index field can carry
	localparam int MAX_SPRITES = 16;

	typedef logic [$clog2(MAX_SPRITES)-1:0] slot_idx_t;

	// which attribute byte of a slot is addressed
	typedef logic [1:0] oam_sel_t;

	localparam oam_sel_t OAM_Y = 2'd0;
	localparam oam_sel_t OAM_X = 2'd1;
	localparam oam_sel_t OAM_TILE = 2'd2;
	localparam oam_sel_t OAM_FLAGS = 2'd3;

	// 2-bit colour index, 0 is transparent
	typedef logic [1:0] color_idx_t;

	// colour-mode palette number
	typedef logic [2:0] gbc_pal_t;

	// flags byte, high bit first
	typedef struct packed {
		// 1: drawn behind background colours 1-3
		logic prio;
		logic y_flip;
		logic x_flip;
		// classic mode palette OBP0/OBP1
		logic pal_dmg;
		// colour mode only, selects video memory bank 1
		logic bank;
		gbc_pal_t pal_gbc;
	} obj_flags_t;

	// one sprite pixel as handed to the rest of the video unit
	typedef struct packed {
		logic active;
		logic pal_dmg;
		logic prio;
		color_idx_t color;
		gbc_pal_t pal_gbc;
		slot_idx_t slot;
	} sprite_pixel_t;

endpackage

`default_nettype wire

//--- hw/sprite_slot.sv
//####################
// one fixed object entry, no OAM scan
// pixel is combinational, slot field is left zero
//####################
`default_nettype none
`timescale 1ns/100ps

module sprite_slot (
	input wire logic clk,
	input wire logic reset,
	input wire logic size16,
	input wire logic gbc_mode,
	input wire gb_video_pkg::coord_t v_cnt,
	input wire gb_video_pkg::coord_t h_cnt,
	input wire logic oam_wr,
	input wire sprite_pkg::oam_sel_t oam_sel,
	input wire gb_video_pkg::vram_byte_t oam_di,
	output gb_video_pkg::vram_byte_t oam_do,
	output gb_video_pkg::tile_row_t row_addr,
	input wire logic load_lo,
	input wire logic load_hi,
	input wire gb_video_pkg::vram_byte_t vram_data,
	input wire gb_video_pkg::vram_byte_t vram_data_1,
	output gb_video_pkg::coord_t x_pos,
	output logic on_line,
	output sprite_pkg::sprite_pixel_t pixel
);
	import gb_video_pkg::*;
	import sprite_pkg::*;

	coord_t y_pos;
	vram_byte_t tile;
	obj_flags_t flags;
	vram_byte_t plane_lo;
	vram_byte_t plane_hi;
	vram_byte_t bank_data;
	logic [4:0] height;
	logic [8:0] v_rel;
	logic [8:0] h_rel;
	logic [3:0] row;
	logic [2:0] col;
	logic h_hit;
	color_idx_t color;

	// attribute bytes, all zero after reset
	// y=0 keeps the sprite above the visible area
	always_ff @(posedge clk) begin
		if (reset) begin
			y_pos <= '0;
			x_pos <= '0;
			tile <= '0;
			flags <= '0;
		end else if (oam_wr) begin
			case (oam_sel)
				OAM_Y: y_pos <= oam_di;
				OAM_X: x_pos <= oam_di;
				OAM_TILE: tile <= oam_di;
				default: flags <= oam_di;
			endcase
		end
	end

	// cpu readback straight from the registers
	always_comb begin
		case (oam_sel)
			OAM_Y: oam_do = y_pos;
			OAM_X: oam_do = x_pos;
			OAM_TILE: oam_do = tile;
			default: oam_do = flags;
		endcase
	end

	assign height = size16 ? 5'd16 : 5'd8;

	// line inside the sprite, 9 bits so lines above the top wrap to large values
	assign v_rel = {1'b0, v_cnt} + 9'(OBJ_Y_OFS) - {1'b0, y_pos};
	assign on_line = (v_rel < 9'(height));

	// vertical mirror, low 3 bits are enough for 8-row sprites
	assign row = flags.y_flip ? ~v_rel[3:0] : v_rel[3:0];

	// tall sprites pair tiles, so the tile lsb is replaced by the row msb
	assign row_addr = size16 ? {tile[7:1], row} : {tile, row[2:0]};

	// bank 1 exists only in colour mode
	assign bank_data = (gbc_mode && flags.bank) ? vram_data_1 : vram_data;

	// plane bytes for the current line
	always_ff @(posedge clk) begin
		if (load_lo) begin
			plane_lo <= bank_data;
		end
		if (load_hi) begin
			plane_hi <= bank_data;
		end
	end

	// column inside the sprite, covered from x-8 to x-1
	assign h_rel = {1'b0, h_cnt} + 9'(OBJ_X_OFS) - {1'b0, x_pos};
	assign h_hit = (h_rel < 9'(OBJ_X_OFS));

	// bit 7 is the leftmost pixel unless mirrored
	assign col = flags.x_flip ? h_rel[2:0] : ~h_rel[2:0];
	assign color = {plane_hi[col], plane_lo[col]};

	always_comb begin
		pixel.active = on_line && h_hit && (color != 2'd0);
		pixel.pal_dmg = flags.pal_dmg;
		pixel.prio = flags.prio;
		pixel.color = color;
		pixel.pal_gbc = flags.pal_gbc;
		// filled in by the mixer
		pixel.slot = '0;
	end

endmodule

`default_nettype wire

//--- hw/sprite_fetch.sv
//####################
// plane fetch for all slots after line_start, 2 cycles per slot
// memory must answer exactly one cycle after the address
//####################
`default_nettype none
`timescale 1ns/100ps

module sprite_fetch #(
	parameter int NUM_SPRITES = 10,
	localparam int CNT_W = $clog2(NUM_SPRITES + 1)
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic line_start,
	input wire gb_video_pkg::tile_row_t [NUM_SPRITES-1:0] row_addrs,
	output gb_video_pkg::vram_addr_t vram_addr,
	output logic [NUM_SPRITES-1:0] load_lo,
	output logic [NUM_SPRITES-1:0] load_hi,
	output logic fetch_done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DONE
	} state_t;

	state_t state;

	// slot counter runs one past the last slot for the final store cycle
	logic [CNT_W-1:0] slot;
	logic plane;
	logic issue;

	// copy of the address just issued, used when its data returns
	logic ld_valid;
	logic [CNT_W-1:0] ld_slot;
	logic ld_plane;

	assign issue = (state == ST_FETCH) && (slot != CNT_W'(NUM_SPRITES));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			slot <= '0;
			plane <= 1'b0;
		end else if (line_start) begin
			// also restarts a fetch already running
			state <= ST_FETCH;
			slot <= '0;
			plane <= 1'b0;
		end else begin
			case (state)
				ST_FETCH: begin
					if (slot == CNT_W'(NUM_SPRITES)) begin
						// last plane is stored on this edge
						state <= ST_DONE;
					end else begin
						plane <= ~plane;
						if (plane) begin
							slot <= slot + 1'b1;
						end
					end
				end
				default: begin
					// idle or done, wait for the next line
					state <= state;
				end
			endcase
		end
	end

	assign vram_addr = issue ? {row_addrs[slot], plane} : '0;

	// a restart drops the store of the address in flight
	always_ff @(posedge clk) begin
		if (reset) begin
			ld_valid <= 1'b0;
		end else begin
			ld_valid <= issue && !line_start;
		end
		ld_slot <= slot;
		ld_plane <= plane;
	end

	// one-hot strobe in the cycle the data is on the bus
	always_comb begin
		for (int i = 0; i < NUM_SPRITES; i++) begin
			load_lo[i] = ld_valid && !ld_plane && (ld_slot == CNT_W'(i));
			load_hi[i] = ld_valid && ld_plane && (ld_slot == CNT_W'(i));
		end
	end

	assign fetch_done = (state == ST_DONE);

endmodule

`default_nettype wire

//--- hw/sprite_mixer.sv
//####################
// picks one sprite pixel per position, one cycle latency
// classic mode: lowest x wins, colour mode: lowest slot wins
//####################
`default_nettype none
`timescale 1ns/100ps

module sprite_mixer #(
	parameter int NUM_SPRITES = 10
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic gbc_mode,
	input wire sprite_pkg::sprite_pixel_t [NUM_SPRITES-1:0] slot_pixels,
	input wire gb_video_pkg::coord_t [NUM_SPRITES-1:0] slot_x,
	input wire logic [NUM_SPRITES-1:0] slot_on_line,
	output sprite_pkg::sprite_pixel_t spr_pixel
);
	import gb_video_pkg::*;
	import sprite_pkg::*;

	// key of a sprite that is not on this line, lowest priority
	localparam coord_t KEY_NONE = 8'hff;

	coord_t [NUM_SPRITES-1:0] key;
	coord_t best_key;
	sprite_pixel_t best;

	// priority key per slot, smaller wins
	always_comb begin
		for (int i = 0; i < NUM_SPRITES; i++) begin
			if (gbc_mode) begin
				key[i] = coord_t'(i);
			end else if (slot_on_line[i]) begin
				key[i] = slot_x[i];
			end else begin
				key[i] = KEY_NONE;
			end
		end
	end

	// linear scan from slot 0
	// strict compare keeps the lower index on equal keys
	always_comb begin
		best = '0;
		best_key = KEY_NONE;
		for (int i = 0; i < NUM_SPRITES; i++) begin
			if (slot_pixels[i].active && (!best.active || (key[i] < best_key))) begin
				best = slot_pixels[i];
				best.slot = slot_idx_t'(i);
				best_key = key[i];
			end
		end
	end

	// all fields zero when nothing is active
	always_ff @(posedge clk) begin
		if (reset) begin
			spr_pixel <= '0;
		end else begin
			spr_pixel <= best;
		end
	end

endmodule

`default_nettype wire

//--- hw/sprite_engine.sv
//####################
// object layer top, NUM_SPRITES from 1 to 16
// oam_addr is the slot index followed by the 2-bit byte select
//####################
`default_nettype none
`timescale 1ns/100ps

module sprite_engine #(
	parameter int NUM_SPRITES = 10,
	localparam int IDX_W = (NUM_SPRITES > 1) ? $clog2(NUM_SPRITES) : 1
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic size16,
	input wire logic gbc_mode,
	input wire gb_video_pkg::coord_t v_cnt,
	input wire gb_video_pkg::coord_t h_cnt,
	input wire logic oam_wr,
	input wire logic [IDX_W+1:0] oam_addr,
	input wire gb_video_pkg::vram_byte_t oam_di,
	output gb_video_pkg::vram_byte_t oam_do,
	input wire logic line_start,
	output logic fetch_done,
	output gb_video_pkg::vram_addr_t vram_addr,
	input wire gb_video_pkg::vram_byte_t vram_data,
	input wire gb_video_pkg::vram_byte_t vram_data_1,
	output sprite_pkg::sprite_pixel_t spr_pixel
);
	import gb_video_pkg::*;
	import sprite_pkg::*;

	logic [IDX_W-1:0] oam_slot;
	oam_sel_t oam_sel;
	logic [NUM_SPRITES-1:0] slot_wr;
	vram_byte_t [NUM_SPRITES-1:0] slot_do;
	tile_row_t [NUM_SPRITES-1:0] row_addrs;
	logic [NUM_SPRITES-1:0] load_lo;
	logic [NUM_SPRITES-1:0] load_hi;
	coord_t [NUM_SPRITES-1:0] slot_x;
	logic [NUM_SPRITES-1:0] on_line;
	sprite_pixel_t [NUM_SPRITES-1:0] slot_pixels;

	assign {oam_slot, oam_sel} = oam_addr;

	// per-slot write enable and read mux
	// indices past the last slot read as zero and write nothing
	always_comb begin
		slot_wr = '0;
		oam_do = '0;
		for (int i = 0; i < NUM_SPRITES; i++) begin
			if (oam_slot == IDX_W'(i)) begin
				slot_wr[i] = oam_wr;
				oam_do = slot_do[i];
			end
		end
	end

	for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_slot
		sprite_slot u_slot (
			.clk(clk),
			.reset(reset),
			.size16(size16),
			.gbc_mode(gbc_mode),
			.v_cnt(v_cnt),
			.h_cnt(h_cnt),
			.oam_wr(slot_wr[i]),
			.oam_sel(oam_sel),
			.oam_di(oam_di),
			.oam_do(slot_do[i]),
			.row_addr(row_addrs[i]),
			.load_lo(load_lo[i]),
			.load_hi(load_hi[i]),
			.vram_data(vram_data),
			.vram_data_1(vram_data_1),
			.x_pos(slot_x[i]),
			.on_line(on_line[i]),
			.pixel(slot_pixels[i])
		);
	end

	// walks the slots once per line
	sprite_fetch #(
		.NUM_SPRITES(NUM_SPRITES)
	) u_fetch (
		.clk(clk),
		.reset(reset),
		.line_start(line_start),
		.row_addrs(row_addrs),
		.vram_addr(vram_addr),
		.load_lo(load_lo),
		.load_hi(load_hi),
		.fetch_done(fetch_done)
	);

	sprite_mixer #(
		.NUM_SPRITES(NUM_SPRITES)
	) u_mixer (
		.clk(clk),
		.reset(reset),
		.gbc_mode(gbc_mode),
		.slot_pixels(slot_pixels),
		.slot_x(slot_x),
		.slot_on_line(on_line),
		.spr_pixel(spr_pixel)
	);

endmodule

`default_nettype wire

//--- sim/sprite_model.svh
//####################
// reference rules of the object layer, included inside the testbench module
// needs NUM_SPRITES and both video memory arrays declared before the include
//####################
`ifndef SPRITE_MODEL_SVH
`define SPRITE_MODEL_SVH

// attribute bytes as last written over the OAM bus, [slot][byte select]
vram_byte_t shadow [NUM_SPRITES][4];

function automatic void shadow_clear();
	for (int s = 0; s < NUM_SPRITES; s++) begin
		for (int b = 0; b < 4; b++) begin
			shadow[s][b] = 8'h00;
		end
	end
endfunction

// screen line counted from the sprite top
// stored y carries +16, lines above the top wrap to large values
function automatic logic [8:0] line_offset(int s, coord_t v);
	return 9'(v) + 9'd16 - 9'(shadow[s][OAM_Y]);
endfunction

function automatic logic is_visible(int s, coord_t v, logic tall);
	return line_offset(s, v) < (tall ? 9'd16 : 9'd8);
endfunction

// tile number and row inside the tile
// tall sprites use the even tile of a pair, the row picks the half
function automatic tile_row_t tile_row(int s, coord_t v, logic tall);
	obj_flags_t f;
	logic [8:0] dy;
	logic [3:0] r4;
	logic [2:0] r3;
	f = shadow[s][OAM_FLAGS];
	dy = line_offset(s, v);
	if (tall) begin
		r4 = f.y_flip ? 4'(15 - int'(dy[3:0])) : dy[3:0];
		return {shadow[s][OAM_TILE][7:1], r4};
	end
	r3 = f.y_flip ? 3'(7 - int'(dy[2:0])) : dy[2:0];
	return {shadow[s][OAM_TILE], r3};
endfunction

// byte address of one plane, plane bit at the bottom
function automatic vram_addr_t fetch_addr(int s, logic plane, coord_t v, logic tall);
	return {tile_row(s, v, tall), plane};
endfunction

// pixel a single sprite would show at position h
function automatic sprite_pixel_t pixel_of(int s, coord_t v, coord_t h, logic tall, logic gbc);
	obj_flags_t f;
	logic [8:0] dx;
	vram_addr_t base;
	vram_byte_t lo;
	vram_byte_t hi;
	int bit_i;
	sprite_pixel_t p;
	f = shadow[s][OAM_FLAGS];
	// stored x carries +8, sprite covers x-8 .. x-1
	dx = 9'(h) + 9'd8 - 9'(shadow[s][OAM_X]);
	base = fetch_addr(s, 1'b0, v, tall);
	// second bank only in colour mode
	if (gbc && f.bank) begin
		lo = vram_bank1[base];
		hi = vram_bank1[base | 12'h001];
	end else begin
		lo = vram_bank0[base];
		hi = vram_bank0[base | 12'h001];
	end
	// msb is the leftmost pixel unless mirrored
	bit_i = f.x_flip ? int'(dx[2:0]) : 7 - int'(dx[2:0]);
	p = '0;
	if (is_visible(s, v, tall) && (dx < 9'd8) && ({hi[bit_i], lo[bit_i]} != 2'b00)) begin
		p.active = 1'b1;
		p.pal_dmg = f.pal_dmg;
		p.prio = f.prio;
		p.color = {hi[bit_i], lo[bit_i]};
		p.pal_gbc = f.pal_gbc;
		p.slot = slot_idx_t'(s);
	end
	return p;
endfunction

// winner among all slots
// classic picks lowest x, colour picks lowest slot, equal keys keep the lower slot
function automatic sprite_pixel_t model_winner(coord_t v, coord_t h, logic tall, logic gbc);
	sprite_pixel_t best;
	sprite_pixel_t p;
	int best_key;
	int key;
	best = '0;
	best_key = 1000;
	for (int s = 0; s < NUM_SPRITES; s++) begin
		p = pixel_of(s, v, h, tall, gbc);
		key = gbc ? s : int'(shadow[s][OAM_X]);
		if (p.active && (key < best_key)) begin
			best = p;
			best_key = key;
		end
	end
	return best;
endfunction

`endif

//--- sim/tb_sprite_engine.sv
//####################
// random OAM contents and line sweeps checked against the included model
// NUM_SPRITES is 10, video memory gets random bytes once before reset ends
//####################
`default_nettype none
`timescale 1ns/100ps

module tb_sprite_engine;
	import gb_video_pkg::*;
	import sprite_pkg::*;

	localparam int NUM_SPRITES = 10;
	localparam int IDX_W = 4;
	// a fetch needs 2*NUM_SPRITES+1 cycles, leave plenty of margin
	localparam int FETCH_TIMEOUT = 4 * NUM_SPRITES + 20;
	localparam int RANDOM_LINES = 12;

	logic clk = 1'b0;
	logic reset;
	logic size16;
	logic gbc_mode;
	coord_t v_cnt;
	coord_t h_cnt;
	logic oam_wr;
	logic [IDX_W+1:0] oam_addr;
	vram_byte_t oam_di;
	vram_byte_t oam_do;
	logic line_start;
	logic fetch_done;
	vram_addr_t vram_addr;
	vram_byte_t vram_data = 8'h00;
	vram_byte_t vram_data_1 = 8'h00;
	sprite_pixel_t spr_pixel;

	// tile area of both banks
	vram_byte_t vram_bank0 [4096];
	vram_byte_t vram_bank1 [4096];

	int checks = 0;
	int errors = 0;
	logic timed_out = 1'b0;

	`include "sprite_model.svh"

	sprite_engine #(
		.NUM_SPRITES(NUM_SPRITES)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.size16(size16),
		.gbc_mode(gbc_mode),
		.v_cnt(v_cnt),
		.h_cnt(h_cnt),
		.oam_wr(oam_wr),
		.oam_addr(oam_addr),
		.oam_di(oam_di),
		.oam_do(oam_do),
		.line_start(line_start),
		.fetch_done(fetch_done),
		.vram_addr(vram_addr),
		.vram_data(vram_data),
		.vram_data_1(vram_data_1),
		.spr_pixel(spr_pixel)
	);

	always #20 clk = ~clk;

	// both banks answer one cycle after the address
	always @(posedge clk) begin
		vram_data <= vram_bank0[vram_addr];
		vram_data_1 <= vram_bank1[vram_addr];
	end

	// all tasks start and end 2 ns after a rising edge
	task automatic oam_write(input int s, input oam_sel_t sel, input vram_byte_t d);
		oam_addr = {IDX_W'(s), sel};
		oam_di = d;
		oam_wr = 1'b1;
		@(posedge clk);
		#2;
		oam_wr = 1'b0;
		shadow[s][sel] = d;
	endtask

	// readback is combinational, sampled mid-cycle
	task automatic oam_expect(input int s, input oam_sel_t sel);
		oam_addr = {IDX_W'(s), sel};
		@(negedge clk);
		checks++;
		if (oam_do !== shadow[s][sel]) begin
			errors++;
			$display("ERROR slot %0d byte %0d: oam_do=%h expected %h", s, sel, oam_do,
				shadow[s][sel]);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic set_sprite(input int s, input vram_byte_t y, input vram_byte_t x,
		input vram_byte_t tile, input vram_byte_t flags);
		oam_write(s, OAM_Y, y);
		oam_write(s, OAM_X, x);
		oam_write(s, OAM_TILE, tile);
		oam_write(s, OAM_FLAGS, flags);
	endtask

	task automatic print_summary();
		$display("checks %0d, errors %0d", checks, errors);
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		checks++;
		if (fetch_done !== 1'b0) begin
			errors++;
			$display("ERROR fetch_done=%h expected 0", fetch_done);
		end
		checks++;
		if (spr_pixel.active !== 1'b0) begin
			errors++;
			$display("ERROR spr_pixel.active=%h expected 0", spr_pixel.active);
		end
		@(posedge clk);
		#2;
		// shadow is still all zero here
		for (int s = 0; s < NUM_SPRITES; s++) begin
			for (int b = 0; b < 4; b++) begin
				oam_expect(s, oam_sel_t'(b));
			end
		end
	endtask

	// each write is read back in the very next cycle
	task automatic oam_fill_random();
		for (int s = 0; s < NUM_SPRITES; s++) begin
			for (int b = 0; b < 4; b++) begin
				oam_write(s, oam_sel_t'(b), vram_byte_t'($urandom));
				oam_expect(s, oam_sel_t'(b));
			end
		end
	endtask

	// pulse line_start and follow the address sequence until fetch_done
	task automatic run_fetch(input coord_t v, input logic tall);
		int cyc;
		int exp_slot;
		logic exp_plane;
		vram_addr_t exp_addr;
		logic done_seen;
		line_start = 1'b1;
		@(posedge clk);
		#2;
		line_start = 1'b0;
		cyc = 1;
		done_seen = 1'b0;
		while (!done_seen && !timed_out) begin
			@(negedge clk);
			if (fetch_done) begin
				if (cyc < 2 * NUM_SPRITES + 2) begin
					errors++;
					$display("fetch_done rose %0d cycles after line_start, too early", cyc - 1);
				end
				done_seen = 1'b1;
			end else if (cyc <= 2 * NUM_SPRITES) begin
				// slot order, plane 0 first
				exp_slot = (cyc - 1) / 2;
				exp_plane = 1'((cyc - 1) % 2);
				exp_addr = fetch_addr(exp_slot, exp_plane, v, tall);
				checks++;
				if (vram_addr !== exp_addr) begin
					errors++;
					$display("ERROR slot %0d plane %0d: vram_addr=%h expected %h", exp_slot,
						exp_plane, vram_addr, exp_addr);
				end
			end
			if (!done_seen && (cyc >= FETCH_TIMEOUT)) begin
				errors++;
				$display("timeout, fetch_done still low %0d cycles after line_start", cyc);
				timed_out = 1'b1;
			end
			@(posedge clk);
			#2;
			cyc++;
		end
	endtask

	// h_cnt one value per cycle, result shows one cycle later
	task automatic sweep_line(input coord_t v, input logic tall, input logic gbc);
		sprite_pixel_t exp_px;
		for (int h = 0; h <= 168; h++) begin
			if (h < 168) begin
				h_cnt = coord_t'(h);
			end
			@(negedge clk);
			if (h > 0) begin
				exp_px = model_winner(v, coord_t'(h - 1), tall, gbc);
				checks++;
				if (spr_pixel !== exp_px) begin
					errors++;
					$display("ERROR line %0d h %0d: spr_pixel=%h expected %h", v, h - 1,
						spr_pixel, exp_px);
				end
			end
			@(posedge clk);
			#2;
		end
	endtask

	task automatic run_line(input coord_t v, input logic tall, input logic gbc);
		if (!timed_out) begin
			v_cnt = v;
			size16 = tall;
			gbc_mode = gbc;
			h_cnt = 8'h00;
			run_fetch(v, tall);
		end
		if (!timed_out) begin
			sweep_line(v, tall, gbc);
		end
	endtask

	// most sprites land on or just around the line
	task automatic randomize_line(input coord_t v);
		for (int s = 0; s < NUM_SPRITES; s++) begin
			set_sprite(s, vram_byte_t'(int'(v) + 16 - int'($urandom_range(0, 19))),
				vram_byte_t'($urandom_range(0, 175)), vram_byte_t'($urandom),
				vram_byte_t'($urandom));
		end
	endtask

	// equal x pairs, both screen edges, tall flipped sprites on odd tiles
	task automatic place_edge_cases(input coord_t v);
		vram_byte_t y_row2;
		vram_byte_t y_row10;
		y_row2 = vram_byte_t'(int'(v) + 14);
		// lower half of a tall sprite
		y_row10 = vram_byte_t'(int'(v) + 6);
		set_sprite(0, y_row2, 8'd40, vram_byte_t'($urandom), vram_byte_t'($urandom));
		set_sprite(1, y_row2, 8'd40, vram_byte_t'($urandom), vram_byte_t'($urandom));
		set_sprite(2, y_row2, 8'd0, vram_byte_t'($urandom), vram_byte_t'($urandom));
		set_sprite(3, y_row2, 8'd168, vram_byte_t'($urandom), vram_byte_t'($urandom));
		set_sprite(4, y_row2, 8'd8, vram_byte_t'($urandom), vram_byte_t'($urandom));
		set_sprite(5, y_row10, 8'd60, vram_byte_t'($urandom) | 8'h01,
			8'h40 | (vram_byte_t'($urandom) & 8'h9f));
		set_sprite(6, y_row10, 8'd62, vram_byte_t'($urandom) | 8'h01,
			8'h60 | (vram_byte_t'($urandom) & 8'h9f));
		set_sprite(7, y_row2, 8'd100, vram_byte_t'($urandom), vram_byte_t'($urandom));
		set_sprite(8, y_row2, 8'd100, vram_byte_t'($urandom), vram_byte_t'($urandom));
		set_sprite(9, y_row10, 8'd100, vram_byte_t'($urandom) | 8'h01,
			vram_byte_t'($urandom));
	endtask

	initial begin
		coord_t v;
		coord_t edge_lines [3];
		reset = 1'b1;
		size16 = 1'b0;
		gbc_mode = 1'b0;
		v_cnt = 8'h00;
		h_cnt = 8'h00;
		oam_wr = 1'b0;
		oam_addr = '0;
		oam_di = 8'h00;
		line_start = 1'b0;
		void'($urandom(32'h4022_393b));
		for (int a = 0; a < 4096; a++) begin
			vram_bank0[a] = vram_byte_t'($urandom);
			vram_bank1[a] = vram_byte_t'($urandom);
		end
		shadow_clear();
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		check_reset_state();

		// full readback after two rounds of random writes
		for (int n = 0; n < 2; n++) begin
			oam_fill_random();
		end
		for (int s = 0; s < NUM_SPRITES; s++) begin
			for (int b = 0; b < 4; b++) begin
				oam_expect(s, oam_sel_t'(b));
			end
		end

		// classic mode, bank bits present but ignored
		for (int n = 0; n < RANDOM_LINES; n++) begin
			v = coord_t'($urandom_range(0, 143));
			randomize_line(v);
			run_line(v, 1'($urandom_range(0, 1)), 1'b0);
		end

		// colour mode
		for (int n = 0; n < RANDOM_LINES; n++) begin
			v = coord_t'($urandom_range(0, 143));
			randomize_line(v);
			run_line(v, 1'($urandom_range(0, 1)), 1'b1);
		end

		// top, middle and bottom line, both sizes and both modes
		edge_lines[0] = 8'd0;
		edge_lines[1] = 8'd77;
		edge_lines[2] = 8'd143;
		for (int n = 0; n < 3; n++) begin
			place_edge_cases(edge_lines[n]);
			run_line(edge_lines[n], 1'b1, 1'b0);
			run_line(edge_lines[n], 1'b0, 1'b0);
			run_line(edge_lines[n], 1'b1, 1'b1);
			run_line(edge_lines[n], 1'b0, 1'b1);
		end

		print_summary();
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+sim
hw/gb_video_pkg.sv
hw/sprite_pkg.sv
hw/sprite_slot.sv
hw/sprite_fetch.sv
hw/sprite_mixer.sv
hw/sprite_engine.sv
sim/tb_sprite_engine.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# success only if the simulation output holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sprite_engine \
	-f verilog.f -o Vtb_sprite_engine \
	&& ./obj_dir/Vtb_sprite_engine | tee /dev/stderr | grep -qxF '** PASS **' \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
